// ==== fetch_pkg.sv ====
package fetch_pkg;

    // ******************************
    // widths and sizes
    // ******************************
    localparam int addr_w    = 32;
    localparam int rom_depth = 256;
    localparam int rom_aw    = 8;

    // opcodes seen by the predecoder.
    localparam logic [5:0] op_j   = 6'b000010;
    localparam logic [5:0] op_beq = 6'b000100;

    // bus size code for one full word.
    localparam logic [1:0] size_word = 2'b10;

    // nonzero start value for the memory delay generator.
    localparam logic [7:0] lfsr_seed = 8'hb5;

    // fetch fsm encoding.
    localparam logic [1:0] st_idle = 2'b00;
    localparam logic [1:0] st_hdsk = 2'b01;
    localparam logic [1:0] st_wait = 2'b10;
    localparam logic [1:0] st_recv = 2'b11;

    // memory side fsm encoding.
    localparam logic [1:0] rom_idle = 2'b00;
    localparam logic [1:0] rom_addr = 2'b01;
    localparam logic [1:0] rom_data = 2'b10;

    // ******************************
    // types
    // ******************************
    typedef union packed {
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i_fmt;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target;
        } j_fmt;
    } instr_u;

    // one completed fetch.
    typedef struct packed {
        logic [addr_w-1:0] pc;
        instr_u            instr;
    } fetch_t;

    // request half of the bus, no write data on this path.
    typedef struct packed {
        logic              req;
        logic              wr;
        logic [1:0]        size;
        logic [addr_w-1:0] addr;
    } bus_req_t;

endpackage

// ==== fetch_pc_gen.sv ====
`timescale 1ns/100ps

module fetch_pc_gen (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         hold,
    input  logic                         stall,
    input  logic                         fetch_valid,
    input  fetch_pkg::fetch_t            result,
    output logic                         is_newPC,
    output logic [fetch_pkg::addr_w-1:0] PC
);
    import fetch_pkg::*;

    logic [addr_w-1:0] pc_q;
    logic [addr_w-1:0] pc_plus4;
    logic [addr_w-1:0] br_off;
    logic [addr_w-1:0] next_pc;
    logic              busy_q;
    logic              is_j;
    logic              is_beq_taken;
    instr_u            word;

    // ******************************
    // next pc predecode
    // ******************************
    assign word     = result.instr;
    assign pc_plus4 = pc_q + 32'd4;

    // sign extended word offset.
    assign br_off = {{14{word.i_fmt.imm[15]}}, word.i_fmt.imm, 2'b00};

    assign is_j = (word.j_fmt.opcode == op_j);

    // taken only when both register numbers match.
    assign is_beq_taken = (word.i_fmt.opcode == op_beq) &&
                          (word.i_fmt.rs == word.i_fmt.rt);

    always_comb begin
        if (is_j) begin
            next_pc = {pc_plus4[31:28], word.j_fmt.target, 2'b00};
        end else if (is_beq_taken) begin
            next_pc = pc_plus4 + br_off;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // ******************************
    // pc and strobe
    // ******************************
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= '0;
        end else if (fetch_valid) begin
            pc_q <= next_pc;
        end
    end

    // set while a fetch is in flight.
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
        end else if (is_newPC) begin
            busy_q <= 1'b1;
        end else if (fetch_valid) begin
            busy_q <= 1'b0;
        end
    end

    assign is_newPC = !busy_q && !hold;
    assign PC       = pc_q;

    // a new fetch only starts once the previous one has let go of stall.
    a_no_strobe_in_stall: assert property (
        @(posedge clk) disable iff (rst)
        (!$past(rst) && is_newPC) |-> !$past(stall)
    );

endmodule

// ==== inst_sram.sv ====
`timescale 1ns/100ps

module inst_sram (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         is_newPC,
    input  logic [fetch_pkg::addr_w-1:0] PC,
    output fetch_pkg::bus_req_t          bus,
    input  logic [fetch_pkg::addr_w-1:0] rdata,
    input  logic                         addr_ok,
    input  logic                         data_ok,
    output logic                         stall,
    output logic                         fetch_valid,
    output fetch_pkg::fetch_t            result
);
    import fetch_pkg::*;

    logic [1:0]        state_q;
    logic [1:0]        state_d;
    logic [addr_w-1:0] addr_q;
    logic [addr_w-1:0] pc_q;
    logic              accept;

    assign accept = bus.req && addr_ok;

    // address kept for the handshake state.
    always_ff @(posedge clk) begin
        if (is_newPC) begin
            addr_q <= PC;
        end
    end

    // pc of the accepted request, paired with rdata later.
    always_ff @(posedge clk) begin
        if (accept) begin
            pc_q <= bus.addr;
        end
    end

    // ******************************
    // state machine
    // ******************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (is_newPC) begin
                    state_d = addr_ok ? st_wait : st_hdsk;
                end
            end
            st_hdsk: begin
                if (addr_ok) begin
                    state_d = st_wait;
                end
            end
            st_wait: begin
                if (data_ok) begin
                    state_d = st_idle;
                end
            end
            // never entered.
            st_recv: state_d = st_idle;
            default: state_d = st_idle;
        endcase
    end

    // request is combinational in idle so it leaves with the strobe.
    always_comb begin
        bus.req     = 1'b0;
        bus.wr      = 1'b0;
        bus.size    = size_word;
        bus.addr    = '0;
        stall       = 1'b0;
        fetch_valid = 1'b0;
        case (state_q)
            st_idle: begin
                if (is_newPC) begin
                    bus.req  = 1'b1;
                    bus.addr = PC;
                    stall    = 1'b1;
                end
            end
            st_hdsk: begin
                bus.req  = 1'b1;
                bus.addr = addr_q;
                stall    = 1'b1;
            end
            st_wait: begin
                stall       = !data_ok;
                fetch_valid = data_ok;
            end
            default: begin
                stall = 1'b0;
            end
        endcase
    end

    assign result = '{pc: pc_q, instr: rdata};

    // ******************************
    // checks
    // ******************************
    a_req_held: assert property (
        @(posedge clk) disable iff (rst)
        (bus.req && !addr_ok) |=> (bus.req && $stable(bus.addr))
    );

    a_no_data_in_idle: assert property (
        @(posedge clk) disable iff (rst)
        (state_q == st_idle) |-> !data_ok
    );

    a_word_aligned: assert property (
        @(posedge clk) disable iff (rst)
        bus.req |-> (bus.addr[1:0] == 2'b00)
    );

endmodule

// ==== inst_rom_slave.sv ====
`timescale 1ns/100ps

module inst_rom_slave (
    input  logic                         clk,
    input  logic                         rst,
    input  fetch_pkg::bus_req_t          bus,
    output logic [fetch_pkg::addr_w-1:0] rdata,
    output logic                         addr_ok,
    output logic                         data_ok,
    input  logic                         load_en,
    input  logic [fetch_pkg::rom_aw-1:0] load_addr,
    input  logic [fetch_pkg::addr_w-1:0] load_data
);
    import fetch_pkg::*;

    logic [addr_w-1:0] mem [rom_depth];
    logic [addr_w-1:0] rdata_q;
    logic [1:0]        state_q;
    logic [1:0]        addr_cnt_q;
    logic [1:0]        data_cnt_q;
    logic [7:0]        lfsr_q;
    logic              lfsr_fb;

    // ******************************
    // storage
    // ******************************
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // word is read when the request is taken.
    always_ff @(posedge clk) begin
        if (addr_ok) begin
            rdata_q <= mem[bus.addr[rom_aw+1:2]];
        end
    end

    // ******************************
    // delay generator
    // ******************************
    assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= lfsr_seed;
        end else begin
            lfsr_q <= {lfsr_q[6:0], lfsr_fb};
        end
    end

    // zero delay accepts in the cycle req rises.
    always_comb begin
        addr_ok = 1'b0;
        if (bus.req) begin
            case (state_q)
                rom_idle: addr_ok = (lfsr_q[1:0] == 2'd0);
                rom_addr: addr_ok = (addr_cnt_q == 2'd0);
                default:  addr_ok = 1'b0;
            endcase
        end
    end

    // ******************************
    // request tracking
    // ******************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= rom_idle;
            addr_cnt_q <= '0;
            data_cnt_q <= '0;
        end else begin
            case (state_q)
                rom_idle: begin
                    if (addr_ok) begin
                        state_q    <= rom_data;
                        data_cnt_q <= lfsr_q[3:2];
                    end else if (bus.req) begin
                        state_q    <= rom_addr;
                        addr_cnt_q <= lfsr_q[1:0] - 2'd1;
                    end
                end
                rom_addr: begin
                    if (addr_ok) begin
                        state_q    <= rom_data;
                        data_cnt_q <= lfsr_q[3:2];
                    end else if (addr_cnt_q != 2'd0) begin
                        addr_cnt_q <= addr_cnt_q - 2'd1;
                    end
                end
                rom_data: begin
                    if (data_cnt_q == 2'd0) begin
                        state_q <= rom_idle;
                    end else begin
                        data_cnt_q <= data_cnt_q - 2'd1;
                    end
                end
                default: state_q <= rom_idle;
            endcase
        end
    end

    assign data_ok = (state_q == rom_data) && (data_cnt_q == 2'd0);
    assign rdata   = rdata_q;

    // one request outstanding at a time.
    a_single_outstanding: assert property (
        @(posedge clk) disable iff (rst)
        addr_ok |=> (!addr_ok until_with data_ok)
    );

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/100ps

module fetch_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         hold,
    input  logic                         load_en,
    input  logic [fetch_pkg::rom_aw-1:0] load_addr,
    input  logic [fetch_pkg::addr_w-1:0] load_data,
    output logic                         fetch_valid,
    output fetch_pkg::fetch_t            fetch_out
);
    import fetch_pkg::*;

    logic              is_newPC;
    logic [addr_w-1:0] pc;
    logic              stall;
    bus_req_t          bus;
    logic [addr_w-1:0] rdata;
    logic              addr_ok;
    logic              data_ok;

    // ******************************
    // sequencer
    // ******************************
    fetch_pc_gen u_pc_gen (
        .clk         (clk),
        .rst         (rst),
        .hold        (hold),
        .stall       (stall),
        .fetch_valid (fetch_valid),
        .result      (fetch_out),
        .is_newPC    (is_newPC),
        .PC          (pc)
    );

    // fetch fsm.
    inst_sram u_fetch (
        .clk         (clk),
        .rst         (rst),
        .is_newPC    (is_newPC),
        .PC          (pc),
        .bus         (bus),
        .rdata       (rdata),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .stall       (stall),
        .fetch_valid (fetch_valid),
        .result      (fetch_out)
    );

    // instruction memory.
    inst_rom_slave u_rom (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus),
        .rdata     (rdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

// ==== tb_fetch.sv ====
`timescale 1ns/100ps

module tb_fetch;
    import fetch_pkg::*;

    localparam int num_fetches    = 400;
    localparam int timeout_cycles = num_fetches * 12 + 300;

    logic              clk;
    logic              rst;
    logic              hold;
    logic              load_en;
    logic [rom_aw-1:0] load_addr;
    logic [addr_w-1:0] load_data;
    logic              fetch_valid;
    fetch_t            fetch_out;

    // testbench copy of the memory and the expected pc.
    logic [31:0] model_mem [rom_depth];
    logic [31:0] model_pc;
    logic        waiting;
    int          checked_cnt = 0;
    int          cycle_cnt   = 0;
    int          j_cnt       = 0;
    int          beq_taken   = 0;
    int          beq_fall    = 0;
    int          high_pc_cnt = 0;

    fetch_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .hold        (hold),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .fetch_valid (fetch_valid),
        .fetch_out   (fetch_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ******************************
    // helpers
    // ******************************
    task automatic abort_run;
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // one random word, a jump, a beq or anything else.
    function automatic logic [31:0] make_word();
        logic [31:0] r;
        int          kind;
        kind = $urandom_range(2, 0);
        r    = $urandom();
        if (kind == 0) begin
            r[31:26] = op_j;
        end else if (kind == 1) begin
            r[31:26] = op_beq;
            // rs equal to rt half of the time.
            if ($urandom_range(1, 0) == 1) begin
                r[20:16] = r[25:21];
            end
        end else begin
            while (r[31:26] == op_j || r[31:26] == op_beq) begin
                r = $urandom();
            end
        end
        return r;
    endfunction

    function automatic logic [31:0] next_pc(input logic [31:0] pc, input logic [31:0] w);
        logic [31:0] seq;
        logic [31:0] off;
        seq = pc + 32'd4;
        off = {{14{w[15]}}, w[15:0], 2'b00};
        if (w[31:26] == op_j) begin
            return {seq[31:28], w[25:0], 2'b00};
        end else if (w[31:26] == op_beq && w[25:21] == w[20:16]) begin
            return seq + off;
        end
        return seq;
    endfunction

    // ******************************
    // response checks
    // ******************************
    always @(posedge clk) begin
        logic [31:0] exp_word;
        if (rst) begin
            model_pc = 32'd0;
            waiting  = 1'b1;
        end else begin
            // no completion until a cycle with hold low has started a fetch.
            if (waiting) begin
                assert (!fetch_valid) else begin
                    $display("Error: %0t fetch_valid got %b expected %b", $time,
                             fetch_valid, 1'b0);
                    abort_run();
                end
                if (!hold) begin
                    waiting = 1'b0;
                end
            end
            if (fetch_valid) begin
                exp_word = model_mem[model_pc[9:2]];
                assert (fetch_out.pc == model_pc) else begin
                    $display("Error: %0t fetch_out.pc got %h expected %h", $time,
                             fetch_out.pc, model_pc);
                    abort_run();
                end
                assert (fetch_out.instr == exp_word) else begin
                    $display("Error: %0t fetch_out.instr got %h expected %h", $time,
                             fetch_out.instr, exp_word);
                    abort_run();
                end
                if (exp_word[31:26] == op_j) begin
                    j_cnt++;
                end else if (exp_word[31:26] == op_beq) begin
                    if (exp_word[25:21] == exp_word[20:16]) begin
                        beq_taken++;
                    end else begin
                        beq_fall++;
                    end
                end
                if (model_pc[31:10] != '0) begin
                    high_pc_cnt++;
                end
                model_pc = next_pc(model_pc, exp_word);
                checked_cnt++;
                waiting = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout after %0d cycles with %0d of %0d fetches checked",
                     cycle_cnt, checked_cnt, num_fetches);
            abort_run();
        end
    end

    // ******************************
    // stimulus
    // ******************************
    initial begin
        logic [31:0] w;
        int          seed_ret;
        seed_ret  = $urandom(32'h0a7c1849);
        rst       = 1'b1;
        hold      = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;

        // preload while the core sits in reset.
        for (int i = 0; i < rom_depth; i++) begin
            w            = make_word();
            model_mem[i] = w;
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= rom_aw'(i);
            load_data <= w;
        end
        @(posedge clk);
        load_en <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // roughly 30 percent hold.
        while (checked_cnt < num_fetches) begin
            @(posedge clk);
            hold <= ($urandom_range(99, 0) < 30);
        end

        $display("fetches %0d, jumps %0d, taken beq %0d, untaken beq %0d, pc above 1 KB %0d",
                 checked_cnt, j_cnt, beq_taken, beq_fall, high_pc_cnt);
        if (j_cnt == 0 || beq_taken == 0 || beq_fall == 0 || high_pc_cnt == 0) begin
            $display("no jump, taken beq, untaken beq or address above 1 KB was fetched");
            abort_run();
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
fetch_pkg.sv
fetch_pc_gen.sv
inst_sram.sv
inst_rom_slave.sv
fetch_top.sv
tb_fetch.sv
